// ==== hdl/csi2_rx_cfg.svh ====
`ifndef CSI2_RX_CFG_SVH
`define CSI2_RX_CFG_SVH

// one byte from each lane forms a 16-bit beat
`define CSI2_DATA_LANES     2

// lane delay steps 0..max, then wraps to 0
`define CSI2_MAX_LANE_DELAY 3

// output buffer depth in beats
`define CSI2_OUT_FIFO_DEPTH 16

`endif

// ==== hdl/csi2_pkg.sv ====
package csi2_pkg;

typedef enum logic [5 : 0] {
  CSI2_DT_FS   = 6'h00,
  CSI2_DT_FE   = 6'h01,
  CSI2_DT_LS   = 6'h02,
  CSI2_DT_LE   = 6'h03,
  CSI2_DT_RAW8 = 6'h2A
} csi2_data_type_e;

typedef enum logic [2 : 0] {
  HDR_IDLE,
  HDR_PAIR0,
  HDR_PAIR1,
  HDR_PAYLOAD,
  HDR_FOOTER
} csi2_hdr_state_e;

// parity bit i covers the header bits set in mask i
localparam logic [23 : 0] ECC_MASK [6] = '{
  24'hF12CB7, 24'hF2555B, 24'h749A6D,
  24'hB8E38E, 24'hDF03F0, 24'hEFFC00
};

function automatic logic [7 : 0] csi2_ecc( input logic [23 : 0] hdr );
  logic [7 : 0] ecc;
  ecc = '0;                                    // p7, p6 stay zero
  for( int i = 0; i < 6; i++ )
    ecc[i] = ^( hdr & ECC_MASK[i] );
  return ecc;
endfunction

endpackage

// ==== hdl/video_pkg.sv ====
package video_pkg;

// lane 0 byte in [7:0], lane 1 byte in [15:8]
typedef logic [15 : 0] pixel_word_t;

typedef logic [1 : 0] beat_keep_t;

localparam beat_keep_t KEEP_BOTH = 2'b11;
localparam beat_keep_t KEEP_LO   = 2'b01;      // odd tail of a line

endpackage

// ==== hdl/csi2_lane_deskew.sv ====
`include "csi2_rx_cfg.svh"

module csi2_lane_deskew
(
  input                              ref_clk_i,
  input                              ref_srst_i,
  input  [`CSI2_DATA_LANES - 1 : 0]  btn_i,
  input  [7 : 0]                     lane0_byte_i,
  input  [7 : 0]                     lane1_byte_i,
  input                              lane0_valid_i,
  input                              lane1_valid_i,
  output logic [7 : 0]               pair_lo_o,
  output logic [7 : 0]               pair_hi_o,
  output logic                       pair_valid_o
);

localparam int TAPS  = `CSI2_MAX_LANE_DELAY + 1;
localparam int DLY_W = $clog2( TAPS );

logic [`CSI2_DATA_LANES - 1 : 0] btn_d1;
logic [`CSI2_DATA_LANES - 1 : 0] btn_d2;
logic [`CSI2_DATA_LANES - 1 : 0] btn_d3;
logic [`CSI2_DATA_LANES - 1 : 0] inc_delay;
logic [7 : 0]                    lane_data [`CSI2_DATA_LANES];
logic [`CSI2_DATA_LANES - 1 : 0] lane_valid;
logic [7 : 0]                    tap_data  [`CSI2_DATA_LANES];
logic [`CSI2_DATA_LANES - 1 : 0] tap_valid;

assign lane_data[0] = lane0_byte_i;
assign lane_data[1] = lane1_byte_i;
assign lane_valid   = { lane1_valid_i, lane0_valid_i };

generate
  for( genvar g = 0; g < `CSI2_DATA_LANES; g++ )
    begin : lane
      logic [DLY_W - 1 : 0] dly;
      logic [7 : 0]         data_sr [TAPS];
      logic [TAPS - 1 : 0]  valid_sr;

      always_ff @( posedge ref_clk_i, posedge ref_srst_i )
        if( ref_srst_i )
          begin
            btn_d1[g] <= 1'b0;
            btn_d2[g] <= 1'b0;
            btn_d3[g] <= 1'b0;
          end
        else
          begin
            btn_d1[g] <= btn_i[g];
            btn_d2[g] <= btn_d1[g];
            btn_d3[g] <= btn_d2[g];
          end

      assign inc_delay[g] = btn_d2[g] && !btn_d3[g];    // rising edge only

      always_ff @( posedge ref_clk_i, posedge ref_srst_i )
        if( ref_srst_i )
          dly <= '0;
        else
          if( inc_delay[g] )
            dly <= ( dly == DLY_W'( `CSI2_MAX_LANE_DELAY ) ) ? '0 : dly + 1'b1;

      always_ff @( posedge ref_clk_i, posedge ref_srst_i )
        if( ref_srst_i )
          valid_sr <= '0;
        else
          valid_sr <= { valid_sr[TAPS - 2 : 0], lane_valid[g] };

      always_ff @( posedge ref_clk_i )
        begin
          data_sr[0] <= lane_data[g];
          for( int i = 1; i < TAPS; i++ )
            data_sr[i] <= data_sr[i - 1];
        end

      assign tap_data[g]  = data_sr[dly];                  // tap 0 is one register
      assign tap_valid[g] = valid_sr[dly];
    end
endgenerate

assign pair_lo_o    = tap_data[0];
assign pair_hi_o    = tap_data[1];
assign pair_valid_o = &tap_valid;

endmodule

// ==== hdl/csi2_header_decoder.sv ====
module csi2_header_decoder
(
  input                              ref_clk_i,
  input                              ref_srst_i,
  input  [7 : 0]                     pair_lo_i,
  input  [7 : 0]                     pair_hi_i,
  input                              pair_valid_i,
  output csi2_pkg::csi2_data_type_e  hdr_type_o,
  output logic [1 : 0]               hdr_vc_o,
  output logic                       sof_o,
  output logic                       sol_o,
  output logic                       ecc_err_o,
  output video_pkg::pixel_word_t     pay_data_o,
  output logic                       pay_valid_o,
  output logic                       pay_last_o,
  output logic                       pay_odd_o
);

import csi2_pkg::*;

csi2_hdr_state_e state;
csi2_data_type_e dt;
logic [7 : 0]    di;
logic [7 : 0]    wc_lo;
logic [15 : 0]   wc;
logic [15 : 0]   remain;                       // payload bytes still to come
logic            is_raw8;
logic            first;
logic            hdr_ok;
logic            tail;

assign wc     = { pair_lo_i, wc_lo };
assign hdr_ok = ( csi2_ecc( { wc, di } ) == pair_hi_i );
assign dt     = csi2_data_type_e'( di[5 : 0] );
assign tail   = ( remain <= 16'd2 );

always_ff @( posedge ref_clk_i, posedge ref_srst_i )
  if( ref_srst_i )
    begin
      state       <= HDR_IDLE;
      di          <= '0;
      wc_lo       <= '0;
      remain      <= '0;
      is_raw8     <= 1'b0;
      first       <= 1'b0;
      hdr_type_o  <= CSI2_DT_FS;
      hdr_vc_o    <= '0;
      sof_o       <= 1'b0;
      sol_o       <= 1'b0;
      ecc_err_o   <= 1'b0;
      pay_valid_o <= 1'b0;
      pay_last_o  <= 1'b0;
      pay_odd_o   <= 1'b0;
    end
  else
    begin
      sof_o       <= 1'b0;
      sol_o       <= 1'b0;
      ecc_err_o   <= 1'b0;
      pay_valid_o <= 1'b0;
      pay_last_o  <= 1'b0;
      pay_odd_o   <= 1'b0;
      case( state )
        HDR_IDLE:
          if( !pair_valid_i )                  // wait for the gap between packets
            state <= HDR_PAIR0;
        HDR_PAIR0:
          if( pair_valid_i )
            begin
              di    <= pair_lo_i;
              wc_lo <= pair_hi_i;
              state <= HDR_PAIR1;
            end
        HDR_PAIR1:
          if( !pair_valid_i )
            state <= HDR_PAIR0;
          else if( !hdr_ok )
            begin
              ecc_err_o <= 1'b1;               // drop the rest of the packet
              state     <= HDR_IDLE;
            end
          else
            begin
              hdr_type_o <= dt;
              hdr_vc_o   <= di[7 : 6];
              if( di[5 : 4] == 2'b00 )         // short packet
                begin
                  sof_o <= ( dt == CSI2_DT_FS );
                  state <= HDR_IDLE;
                end
              else
                begin
                  is_raw8 <= ( dt == CSI2_DT_RAW8 );
                  first   <= 1'b1;
                  remain  <= wc;
                  state   <= ( wc == '0 ) ? HDR_FOOTER : HDR_PAYLOAD;
                end
            end
        HDR_PAYLOAD:
          if( !pair_valid_i )
            state <= HDR_PAIR0;
          else
            begin
              pay_valid_o <= is_raw8;
              sol_o       <= is_raw8 && first;
              pay_last_o  <= tail;
              pay_odd_o   <= ( remain == 16'd1 );
              first       <= 1'b0;
              remain      <= tail ? '0 : remain - 16'd2;
              if( tail )
                state <= HDR_FOOTER;
            end
        HDR_FOOTER:
          state <= HDR_IDLE;                   // crc bytes are not checked
        default:
          state <= HDR_IDLE;
      endcase
    end

always_ff @( posedge ref_clk_i )
  if( pair_valid_i )
    pay_data_o <= { pair_hi_i, pair_lo_i };

endmodule

// ==== hdl/csi2_payload_unpack.sv ====
module csi2_payload_unpack
(
  input                              ref_clk_i,
  input                              ref_srst_i,
  input  csi2_pkg::csi2_data_type_e  hdr_type_i,
  input  [1 : 0]                     hdr_vc_i,
  input                              sof_i,
  input                              sol_i,
  input  video_pkg::pixel_word_t     pay_data_i,
  input                              pay_valid_i,
  input                              pay_last_i,
  input                              pay_odd_i,
  output video_pkg::pixel_word_t     beat_data_o,
  output video_pkg::beat_keep_t      beat_keep_o,
  output logic                       beat_user_o,
  output logic                       beat_last_o,
  output logic [1 : 0]               beat_vc_o,
  output logic                       beat_valid_o
);

import csi2_pkg::*;
import video_pkg::*;

logic fs_pending;                              // frame started, no pixel out yet
logic pix_beat;

assign pix_beat = pay_valid_i && ( hdr_type_i == CSI2_DT_RAW8 );

always_ff @( posedge ref_clk_i, posedge ref_srst_i )
  if( ref_srst_i )
    begin
      fs_pending   <= 1'b0;
      beat_valid_o <= 1'b0;
    end
  else
    begin
      beat_valid_o <= pix_beat;
      if( sof_i )
        fs_pending <= 1'b1;
      else if( pix_beat && sol_i )
        fs_pending <= 1'b0;
    end

always_ff @( posedge ref_clk_i )
  if( pix_beat )
    begin
      beat_data_o <= pay_odd_i ? { 8'h00, pay_data_i[7 : 0] } : pay_data_i;  // hi is crc
      beat_keep_o <= pay_odd_i ? KEEP_LO : KEEP_BOTH;
      beat_user_o <= fs_pending && sol_i;
      beat_last_o <= pay_last_i;
      beat_vc_o   <= hdr_vc_i;
    end

endmodule

// ==== hdl/csi2_video_out.sv ====
`include "csi2_rx_cfg.svh"

module csi2_video_out
(
  input                           ref_clk_i,
  input                           ref_srst_i,
  input  video_pkg::pixel_word_t  beat_data_i,
  input  video_pkg::beat_keep_t   beat_keep_i,
  input                           beat_user_i,
  input                           beat_last_i,
  input  [1 : 0]                  beat_vc_i,
  input                           beat_valid_i,
  input                           video_tready_i,
  output video_pkg::pixel_word_t  video_tdata_o,
  output logic                    video_tvalid_o,
  output video_pkg::beat_keep_t   video_tkeep_o,
  output video_pkg::beat_keep_t   video_tstrb_o,
  output logic                    video_tuser_o,
  output logic [1 : 0]            video_tid_o,
  output logic [1 : 0]            video_tdest_o,
  output logic                    video_tlast_o,
  output logic                    overflow_o
);

import video_pkg::*;

localparam int DEPTH = `CSI2_OUT_FIFO_DEPTH;
localparam int AW    = $clog2( DEPTH );

pixel_word_t   data_mem [DEPTH];
beat_keep_t    keep_mem [DEPTH];
logic [3 : 0]  side_mem [DEPTH];               // user, last, vc
logic [AW : 0] wr_ptr;
logic [AW : 0] rd_ptr;
logic          full;
logic          empty;
logic          wr_en;
logic          rd_en;

assign empty = ( wr_ptr == rd_ptr );
assign full  = ( wr_ptr[AW] != rd_ptr[AW] ) && ( wr_ptr[AW - 1 : 0] == rd_ptr[AW - 1 : 0] );
assign wr_en = beat_valid_i && !full;
assign rd_en = video_tvalid_o && video_tready_i;

always_ff @( posedge ref_clk_i, posedge ref_srst_i )
  if( ref_srst_i )
    begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      overflow_o <= 1'b0;
    end
  else
    begin
      if( wr_en )
        wr_ptr <= wr_ptr + 1'b1;
      if( rd_en )
        rd_ptr <= rd_ptr + 1'b1;
      if( beat_valid_i && full )
        overflow_o <= 1'b1;                    // held until reset
    end

always_ff @( posedge ref_clk_i )
  if( wr_en )
    begin
      data_mem[wr_ptr[AW - 1 : 0]] <= beat_data_i;
      keep_mem[wr_ptr[AW - 1 : 0]] <= beat_keep_i;
      side_mem[wr_ptr[AW - 1 : 0]] <= { beat_user_i, beat_last_i, beat_vc_i };
    end

assign video_tvalid_o = !empty;
assign video_tdata_o  = data_mem[rd_ptr[AW - 1 : 0]];
assign video_tkeep_o  = keep_mem[rd_ptr[AW - 1 : 0]];
assign video_tstrb_o  = video_tkeep_o;
assign { video_tuser_o, video_tlast_o, video_tid_o } = side_mem[rd_ptr[AW - 1 : 0]];
assign video_tdest_o  = video_tid_o;           // vc on both id and dest

endmodule

// ==== hdl/csi2_rx_wrap.sv ====
`include "csi2_rx_cfg.svh"

module csi2_rx_wrap
(
  input                              ref_clk_i,
  input                              ref_srst_i,
  input  [`CSI2_DATA_LANES - 1 : 0]  btn_i,
  input  [7 : 0]                     lane0_byte_i,
  input  [7 : 0]                     lane1_byte_i,
  input                              lane0_valid_i,
  input                              lane1_valid_i,

  input                              video_tready_i,
  output video_pkg::pixel_word_t     video_tdata_o,
  output                             video_tvalid_o,
  output video_pkg::beat_keep_t      video_tkeep_o,
  output video_pkg::beat_keep_t      video_tstrb_o,
  output                             video_tuser_o,
  output [1 : 0]                     video_tid_o,
  output [1 : 0]                     video_tdest_o,
  output                             video_tlast_o,

  output                             ecc_err_o,
  output                             overflow_o
);

import csi2_pkg::*;
import video_pkg::*;

logic [7 : 0]    pair_lo;
logic [7 : 0]    pair_hi;
logic            pair_valid;
csi2_data_type_e hdr_type;
logic [1 : 0]    hdr_vc;
logic            sof;
logic            sol;
pixel_word_t     pay_data;
logic            pay_valid;
logic            pay_last;
logic            pay_odd;
pixel_word_t     beat_data;
beat_keep_t      beat_keep;
logic            beat_user;
logic            beat_last;
logic [1 : 0]    beat_vc;
logic            beat_valid;

csi2_lane_deskew deskew (
  .ref_clk_i     ( ref_clk_i     ),
  .ref_srst_i    ( ref_srst_i    ),
  .btn_i         ( btn_i         ),
  .lane0_byte_i  ( lane0_byte_i  ),
  .lane1_byte_i  ( lane1_byte_i  ),
  .lane0_valid_i ( lane0_valid_i ),
  .lane1_valid_i ( lane1_valid_i ),
  .pair_lo_o     ( pair_lo       ),
  .pair_hi_o     ( pair_hi       ),
  .pair_valid_o  ( pair_valid    )
);

csi2_header_decoder decoder (
  .ref_clk_i     ( ref_clk_i     ),
  .ref_srst_i    ( ref_srst_i    ),
  .pair_lo_i     ( pair_lo       ),
  .pair_hi_i     ( pair_hi       ),
  .pair_valid_i  ( pair_valid    ),
  .hdr_type_o    ( hdr_type      ),
  .hdr_vc_o      ( hdr_vc        ),
  .sof_o         ( sof           ),
  .sol_o         ( sol           ),
  .ecc_err_o     ( ecc_err_o     ),
  .pay_data_o    ( pay_data      ),
  .pay_valid_o   ( pay_valid     ),
  .pay_last_o    ( pay_last      ),
  .pay_odd_o     ( pay_odd       )
);

csi2_payload_unpack unpack (
  .ref_clk_i     ( ref_clk_i     ),
  .ref_srst_i    ( ref_srst_i    ),
  .hdr_type_i    ( hdr_type      ),
  .hdr_vc_i      ( hdr_vc        ),
  .sof_i         ( sof           ),
  .sol_i         ( sol           ),
  .pay_data_i    ( pay_data      ),
  .pay_valid_i   ( pay_valid     ),
  .pay_last_i    ( pay_last      ),
  .pay_odd_i     ( pay_odd       ),
  .beat_data_o   ( beat_data     ),
  .beat_keep_o   ( beat_keep     ),
  .beat_user_o   ( beat_user     ),
  .beat_last_o   ( beat_last     ),
  .beat_vc_o     ( beat_vc       ),
  .beat_valid_o  ( beat_valid    )
);

csi2_video_out video_out (
  .ref_clk_i      ( ref_clk_i      ),
  .ref_srst_i     ( ref_srst_i     ),
  .beat_data_i    ( beat_data      ),
  .beat_keep_i    ( beat_keep      ),
  .beat_user_i    ( beat_user      ),
  .beat_last_i    ( beat_last      ),
  .beat_vc_i      ( beat_vc        ),
  .beat_valid_i   ( beat_valid     ),
  .video_tready_i ( video_tready_i ),
  .video_tdata_o  ( video_tdata_o  ),
  .video_tvalid_o ( video_tvalid_o ),
  .video_tkeep_o  ( video_tkeep_o  ),
  .video_tstrb_o  ( video_tstrb_o  ),
  .video_tuser_o  ( video_tuser_o  ),
  .video_tid_o    ( video_tid_o    ),
  .video_tdest_o  ( video_tdest_o  ),
  .video_tlast_o  ( video_tlast_o  ),
  .overflow_o     ( overflow_o     )
);

endmodule

// ==== verif/csi2_rx_props.sv ====
module csi2_rx_props
(
  input          ref_clk_i,
  input          ref_srst_i,
  input          video_tready_i,
  input [15 : 0] video_tdata_o,
  input          video_tvalid_o,
  input [1 : 0]  video_tkeep_o,
  input [1 : 0]  video_tstrb_o,
  input          video_tuser_o,
  input [1 : 0]  video_tid_o,
  input [1 : 0]  video_tdest_o,
  input          video_tlast_o
);

timeunit 1ns;
timeprecision 100ps;

a_reset_idle: assert property( @( posedge ref_clk_i ) ref_srst_i |-> !video_tvalid_o )
  else $error( "tvalid high during reset" );

// beat must hold until the sink takes it
a_stall_stable: assert property( @( posedge ref_clk_i ) disable iff( ref_srst_i )
  video_tvalid_o && !video_tready_i |=> video_tvalid_o && $stable( video_tdata_o )
  && $stable( video_tkeep_o ) && $stable( video_tuser_o ) && $stable( video_tlast_o )
  && $stable( video_tid_o ) )
  else $error( "stream changed while stalled" );

a_keep_strb: assert property( @( posedge ref_clk_i ) disable iff( ref_srst_i )
  video_tvalid_o |-> video_tkeep_o == video_tstrb_o )
  else $error( "tkeep and tstrb differ" );

a_dest_id: assert property( @( posedge ref_clk_i ) disable iff( ref_srst_i )
  video_tvalid_o |-> video_tdest_o == video_tid_o )
  else $error( "tdest and tid differ" );

endmodule

bind csi2_rx_wrap csi2_rx_props props (
  .ref_clk_i      ( ref_clk_i      ),
  .ref_srst_i     ( ref_srst_i     ),
  .video_tready_i ( video_tready_i ),
  .video_tdata_o  ( video_tdata_o  ),
  .video_tvalid_o ( video_tvalid_o ),
  .video_tkeep_o  ( video_tkeep_o  ),
  .video_tstrb_o  ( video_tstrb_o  ),
  .video_tuser_o  ( video_tuser_o  ),
  .video_tid_o    ( video_tid_o    ),
  .video_tdest_o  ( video_tdest_o  ),
  .video_tlast_o  ( video_tlast_o  )
);

// ==== verif/csi2_rx_tb.sv ====
`include "csi2_rx_cfg.svh"

module csi2_rx_tb;

timeunit 1ns;
timeprecision 100ps;

typedef struct {
  int vc;
  int wc;
  int corrupt;
  int skew;
  int press0;
  int press1;
  int lines;
  int hold;
  int beats;
  int ecc;
  int ovf;
} row_t;

localparam int ROWS    = 7;
localparam int TIMEOUT = 500;

logic         ref_clk_i;
logic         ref_srst_i;
logic [1 : 0] btn_i;
logic [7 : 0] lane0_byte_i;
logic [7 : 0] lane1_byte_i;
logic         lane0_valid_i;
logic         lane1_valid_i;
logic         video_tready_i;
logic [15 : 0] video_tdata_o;
logic         video_tvalid_o;
logic [1 : 0] video_tkeep_o;
logic [1 : 0] video_tstrb_o;
logic         video_tuser_o;
logic [1 : 0] video_tid_o;
logic [1 : 0] video_tdest_o;
logic         video_tlast_o;
logic         ecc_err_o;
logic         overflow_o;

row_t         tbl [ROWS];
logic [8 : 0] l0_q [$];                        // {valid, byte} per cycle
logic [8 : 0] l1_q [$];
bit           hold_q [$];
logic [7 : 0] no_payload [$];
logic [23 : 0] exp_q [$];                      // {user, last, vc, keep, data}
logic [23 : 0] got_q [$];
logic [1 : 0]  got_dest_q [$];
logic [1 : 0]  got_strb_q [$];
bit           ecc_seen;
int           errors;
int           checks;

csi2_rx_wrap dut (
  .ref_clk_i      ( ref_clk_i      ),
  .ref_srst_i     ( ref_srst_i     ),
  .btn_i          ( btn_i          ),
  .lane0_byte_i   ( lane0_byte_i   ),
  .lane1_byte_i   ( lane1_byte_i   ),
  .lane0_valid_i  ( lane0_valid_i  ),
  .lane1_valid_i  ( lane1_valid_i  ),
  .video_tready_i ( video_tready_i ),
  .video_tdata_o  ( video_tdata_o  ),
  .video_tvalid_o ( video_tvalid_o ),
  .video_tkeep_o  ( video_tkeep_o  ),
  .video_tstrb_o  ( video_tstrb_o  ),
  .video_tuser_o  ( video_tuser_o  ),
  .video_tid_o    ( video_tid_o    ),
  .video_tdest_o  ( video_tdest_o  ),
  .video_tlast_o  ( video_tlast_o  ),
  .ecc_err_o      ( ecc_err_o      ),
  .overflow_o     ( overflow_o     )
);

initial
  begin
    ref_clk_i = 1'b0;
    forever #10 ref_clk_i = ~ref_clk_i;
  end

// sampled mid-cycle so a beat counts when it transfers at the next rising edge
always @( negedge ref_clk_i )
  if( !ref_srst_i )
    begin
      if( ecc_err_o )
        ecc_seen = 1'b1;
      if( video_tvalid_o && video_tready_i )
        begin
          got_q.push_back( { video_tuser_o, video_tlast_o, video_tid_o,
                             video_tkeep_o, video_tdata_o } );
          got_dest_q.push_back( video_tdest_o );
          got_strb_q.push_back( video_tstrb_o );
        end
    end

// csi2 hamming parity over {wc_hi, wc_lo, di} with p7 and p6 held at zero
function automatic logic [7 : 0] hamming_ecc( input logic [23 : 0] d );
  logic [7 : 0] p;
  p    = '0;
  p[0] = d[0] ^ d[1] ^ d[2] ^ d[4] ^ d[5] ^ d[7] ^ d[10] ^ d[11] ^ d[13] ^ d[16]
         ^ d[20] ^ d[21] ^ d[22] ^ d[23];
  p[1] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6] ^ d[8] ^ d[10] ^ d[12] ^ d[14] ^ d[17]
         ^ d[20] ^ d[21] ^ d[22] ^ d[23];
  p[2] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6] ^ d[9] ^ d[11] ^ d[12] ^ d[15] ^ d[18]
         ^ d[20] ^ d[21] ^ d[22];
  p[3] = d[1] ^ d[2] ^ d[3] ^ d[7] ^ d[8] ^ d[9] ^ d[13] ^ d[14] ^ d[15] ^ d[19]
         ^ d[20] ^ d[21] ^ d[23];
  p[4] = d[4] ^ d[5] ^ d[6] ^ d[7] ^ d[8] ^ d[9] ^ d[16] ^ d[17] ^ d[18] ^ d[19]
         ^ d[20] ^ d[22] ^ d[23];
  p[5] = d[10] ^ d[11] ^ d[12] ^ d[13] ^ d[14] ^ d[15] ^ d[16] ^ d[17] ^ d[18]
         ^ d[19] ^ d[21] ^ d[22] ^ d[23];
  return p;
endfunction

task automatic add_idle( input int n, input bit hold );
  for( int i = 0; i < n; i++ )
    begin
      l0_q.push_back( 9'h000 );
      l1_q.push_back( 9'h000 );
      hold_q.push_back( hold );
    end
endtask

// lane 0 takes the even bytes and lane 1 the odd ones
task automatic add_packet( input logic [7 : 0] di, input logic [15 : 0] wc, input bit bad,
                           input bit hold, input logic [7 : 0] payload [$] );
  logic [7 : 0] b [$];
  logic [7 : 0] ecc;
  ecc = hamming_ecc( { wc, di } );
  if( bad )
    ecc = ecc ^ 8'h04;
  b = { di, wc[7 : 0], wc[15 : 8], ecc };
  if( di[5 : 4] != 2'b00 )
    begin
      foreach( payload[i] )
        b.push_back( payload[i] );
      b.push_back( 8'( $urandom ) );           // crc bytes the dut drops
      b.push_back( 8'( $urandom ) );
    end
  if( b.size() % 2 )
    b.push_back( 8'h00 );
  for( int i = 0; i < b.size(); i += 2 )
    begin
      l0_q.push_back( { 1'b1, b[i] } );
      l1_q.push_back( { 1'b1, b[i + 1] } );
      hold_q.push_back( hold );
    end
  add_idle( 8, hold );
endtask

task automatic build_frame( input row_t r, input bit bad, input bit expect_out );
  logic [7 : 0] pix [$];
  logic [1 : 0] vc;
  int           nb;
  bit           odd_tail;
  vc = 2'( r.vc );
  nb = ( r.wc + 1 ) / 2;
  add_packet( { vc, 6'h00 }, 16'd1, bad, 1'b0, no_payload );   // frame start
  for( int l = 0; l < r.lines; l++ )
    begin
      pix.delete();
      for( int i = 0; i < r.wc; i++ )
        pix.push_back( 8'( $urandom ) );
      add_packet( { vc, 6'h2A }, 16'( r.wc ), bad, r.hold != 0, pix );
      add_idle( 40, 1'b0 );                    // drain window
      if( expect_out )
        for( int j = 0; j < nb; j++ )
          begin
            odd_tail = ( 2 * j + 1 == r.wc );
            exp_q.push_back( { ( l == 0 && j == 0 ), ( j == nb - 1 ), vc,
                               odd_tail ? 2'b01 : 2'b11,
                               odd_tail ? 8'h00 : pix[2 * j + 1], pix[2 * j] } );
          end
    end
  add_packet( { vc, 6'h01 }, 16'd1, bad, 1'b0, no_payload );   // frame end
endtask

task automatic apply_reset();
  @( posedge ref_clk_i );
  #2 ref_srst_i = 1'b1;
  repeat( 4 ) @( posedge ref_clk_i );
  #2 ref_srst_i = 1'b0;
endtask

task automatic press_buttons( input int n0, input int n1 );
  for( int i = 0; i < n0 || i < n1; i++ )
    begin
      @( posedge ref_clk_i );
      #2 btn_i = { 1'( i < n1 ), 1'( i < n0 ) };
      repeat( 4 ) @( posedge ref_clk_i );
      #2 btn_i = 2'b00;
      repeat( 4 ) @( posedge ref_clk_i );
    end
endtask

task automatic drive_lanes( input int skew );
  int n;
  n = l0_q.size();
  for( int t = 0; t < n + skew; t++ )
    begin
      @( posedge ref_clk_i );
      #2;
      { lane0_valid_i, lane0_byte_i } = ( t < n ) ? l0_q[t] : 9'h000;
      { lane1_valid_i, lane1_byte_i } = ( t >= skew ) ? l1_q[t - skew] : 9'h000;
      if( t < n && hold_q[t] )
        video_tready_i = 1'b0;
      else
        video_tready_i = ( $urandom % 4 ) != 0;      // random ready gaps
    end
  @( posedge ref_clk_i );
  #2 video_tready_i = 1'b1;
endtask

task automatic check_field( input string name, input logic [31 : 0] got,
                            input logic [31 : 0] exp, input int test, input int beat );
  checks++;
  assert( got == exp )
  else
    begin
      $display( "Fail %s got 0x%0h expected 0x%0h in test %0d beat %0d",
                name, got, exp, test, beat );
      errors++;
    end
endtask

task automatic wait_for_beats( input int test, input int want, output bit got_all );
  int cnt;
  cnt = 0;
  while( got_q.size() < want && cnt < TIMEOUT )
    begin
      @( posedge ref_clk_i );
      cnt++;
    end
  got_all = ( got_q.size() >= want );
  if( !got_all )
    begin
      $display( "test %0d timed out with %0d of %0d beats received", test, got_q.size(), want );
      errors++;
    end
  else
    repeat( 10 ) @( posedge ref_clk_i );       // catch stray extra beats
endtask

task automatic check_row( input int r );
  int n;
  checks++;
  assert( got_q.size() == tbl[r].beats && exp_q.size() == tbl[r].beats )
  else
    begin
      $display( "test %0d delivered %0d beats while %0d were expected",
                r, got_q.size(), tbl[r].beats );
      errors++;
    end
  n = ( got_q.size() < exp_q.size() ) ? got_q.size() : exp_q.size();
  for( int i = 0; i < n; i++ )
    begin
      check_field( "video_tdata_o", got_q[i][15 : 0], exp_q[i][15 : 0], r, i );
      check_field( "video_tkeep_o", got_q[i][17 : 16], exp_q[i][17 : 16], r, i );
      check_field( "video_tstrb_o", got_strb_q[i], exp_q[i][17 : 16], r, i );
      check_field( "video_tid_o", got_q[i][19 : 18], exp_q[i][19 : 18], r, i );
      check_field( "video_tdest_o", got_dest_q[i], exp_q[i][19 : 18], r, i );
      check_field( "video_tlast_o", got_q[i][20], exp_q[i][20], r, i );
      check_field( "video_tuser_o", got_q[i][21], exp_q[i][21], r, i );
    end
  check_field( "ecc_err_o", ecc_seen, tbl[r].ecc, r, -1 );
  check_field( "overflow_o", overflow_o, tbl[r].ovf, r, -1 );
endtask

initial
  begin
    int errs_before;
    bit got_all;
    bit timed_out;
    void'( $urandom( 32'hf4d314e7 ) );
    ref_srst_i     = 1'b1;
    btn_i          = 2'b00;
    lane0_byte_i   = 8'h00;
    lane1_byte_i   = 8'h00;
    lane0_valid_i  = 1'b0;
    lane1_valid_i  = 1'b0;
    video_tready_i = 1'b1;
    errors         = 0;
    checks         = 0;
    timed_out      = 1'b0;
    //         vc  wc  bad skew p0 p1 lines hold beats ecc ovf
    tbl[0] = '{ 1, 16, 0,  0,   0, 0, 2,    0,   16,   0,  0 };
    tbl[1] = '{ 2, 11, 0,  0,   0, 0, 2,    0,   12,   0,  0 };
    tbl[2] = '{ 0,  8, 1,  0,   0, 0, 1,    0,    4,   1,  0 };
    tbl[3] = '{ 3, 12, 0,  2,   2, 0, 2,    0,   12,   0,  0 };
    tbl[4] = '{ 1, 24, 0,  0,   0, 0, 3,    1,   36,   0,  0 };
    tbl[5] = '{ 0, 40, 0,  0,   0, 0, 1,    1,   `CSI2_OUT_FIFO_DEPTH, 0, 1 };
    tbl[6] = '{ 2, 10, 0,  3,   7, 4, 2,    0,   10,   0,  0 };
    for( int r = 0; r < ROWS && !timed_out; r++ )
      begin
        errs_before = errors;
        apply_reset();
        l0_q.delete();
        l1_q.delete();
        hold_q.delete();
        exp_q.delete();
        got_q.delete();
        got_dest_q.delete();
        got_strb_q.delete();
        ecc_seen = 1'b0;
        press_buttons( tbl[r].press0, tbl[r].press1 );
        if( tbl[r].corrupt != 0 )
          build_frame( tbl[r], 1'b1, 1'b0 );   // dropped frame before the clean one
        build_frame( tbl[r], 1'b0, 1'b1 );
        while( exp_q.size() > tbl[r].beats && tbl[r].ovf != 0 )
          void'( exp_q.pop_back() );           // beats past a full buffer are lost
        drive_lanes( tbl[r].skew );
        wait_for_beats( r, tbl[r].beats, got_all );
        if( got_all )
          check_row( r );
        else
          timed_out = 1'b1;
        $display( "test %0d %s", r, ( errors == errs_before ) ? "ok" : "has errors" );
      end
    $display( "%0d tests, %0d checks, %0d errors", ROWS, checks, errors );
    if( errors == 0 )
      $display( "Testbench passed" );
    else
      $display( "Testbench failed" );
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+hdl
hdl/csi2_pkg.sv
hdl/video_pkg.sv
hdl/csi2_lane_deskew.sv
hdl/csi2_header_decoder.sv
hdl/csi2_payload_unpack.sv
hdl/csi2_video_out.sv
hdl/csi2_rx_wrap.sv
verif/csi2_rx_props.sv
verif/csi2_rx_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module csi2_rx_tb -f flist.f -o sim_csi2_rx

out=$(./obj_dir/sim_csi2_rx)
echo "$out"

if ! grep -q "Testbench passed" <<< "$out"; then
  exit 1
fi
